// ==== xcel_defs.svh ====
// width, depth and credit macros shared by the accelerator tile
`ifndef XCEL_DEFS_SVH
`define XCEL_DEFS_SVH

// network word and coordinate widths
`define XCEL_DATA_W 32
`define XCEL_X_W 4
`define XCEL_Y_W 4

// word address inside a tile
`define XCEL_EPA_W 22

// load id doubles as the element index, so LEN tops out at 256
`define XCEL_LOAD_ID_W 8

`define XCEL_MAX_CREDITS 8
`define XCEL_FIFO_DEPTH 4

`endif

// ==== net_pkg.sv ====
// network packet op and field types, queued request and return records
`include "xcel_defs.svh"

package net_pkg;

  typedef enum logic [0:0] {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } op_e;

  typedef logic [`XCEL_X_W-1:0] coord_x_t;
  typedef logic [`XCEL_Y_W-1:0] coord_y_t;
  typedef logic [`XCEL_EPA_W-1:0] epa_t;
  typedef logic [`XCEL_LOAD_ID_W-1:0] load_id_t;
  typedef logic [`XCEL_DATA_W-1:0] data_t;
  typedef logic [`XCEL_DATA_W/8-1:0] mask_t;

  // incoming request as held in the request queue
  typedef struct packed {
    op_e      op;
    epa_t     epa;
    data_t    data;
    mask_t    mask;
    coord_x_t src_x;
    coord_y_t src_y;
  } slave_req_t;

  typedef struct packed {
    data_t    data;
    load_id_t load_id;
  } ret_t;

endpackage

// ==== xcel_pkg.sv ====
// accelerator CSR map and FSM state encoding

package xcel_pkg;

  // word index of each CSR within the tile
  typedef enum logic [3:0] {
    CSR_GO       = 4'd0,
    CSR_SRC      = 4'd1,
    CSR_DST      = 4'd2,
    CSR_LEN      = 4'd3,
    CSR_SCALE    = 4'd4,
    CSR_SUM      = 4'd5,
    CSR_PROF_CSR = 4'd6,
    CSR_PROF_LD  = 4'd7,
    CSR_PROF_RET = 4'd8
  } csr_e;

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    RUN   = 2'd1,
    DRAIN = 2'd2
  } xcel_state_e;

endpackage

// ==== stream_fifo.sv ====
// circular-buffer FIFO with a type-parameterized element
`timescale 1ns/1ps
`include "xcel_defs.svh"

module stream_fifo #(
  parameter type elem_t = logic [7:0]
) (
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  push_i,
  input  elem_t data_i,
  input  logic  pop_i,
  output elem_t data_o,
  output logic  v_o,
  output logic  full_o
);

  localparam int DEPTH = `XCEL_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  elem_t            mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             do_push;
  logic             do_pop;

  assign v_o     = (count_q != '0);
  assign full_o  = (count_q == (PTR_W+1)'(DEPTH));
  assign data_o  = mem_q[rd_ptr_q];
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && v_o;

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

endmodule

// ==== net_endpoint.sv ====
// network endpoint: request queue, reply routing, load credits
// and returned-data queue
`timescale 1ns/1ps
`include "xcel_defs.svh"

module net_endpoint (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                req_in_v_i,
  input  net_pkg::op_e        req_in_op_i,
  input  net_pkg::epa_t       req_in_epa_i,
  input  net_pkg::data_t      req_in_data_i,
  input  net_pkg::mask_t      req_in_mask_i,
  input  net_pkg::coord_x_t   req_in_src_x_i,
  input  net_pkg::coord_y_t   req_in_src_y_i,
  input  logic                ret_in_v_i,
  input  net_pkg::data_t      ret_in_data_i,
  input  net_pkg::load_id_t   ret_in_load_id_i,
  output logic                in_v_o,
  output net_pkg::slave_req_t in_req_o,
  input  logic                in_yumi_i,
  input  logic                returning_v_i,
  input  net_pkg::data_t      returning_data_i,
  output logic                rep_v_o,
  output net_pkg::data_t      rep_data_o,
  output net_pkg::coord_x_t   rep_dst_x_o,
  output net_pkg::coord_y_t   rep_dst_y_o,
  input  logic                out_v_i,
  input  net_pkg::op_e        out_op_i,
  input  logic                net_ready_i,
  output logic                out_ready_o,
  output logic                returned_v_o,
  output net_pkg::ret_t       returned_o,
  input  logic                returned_yumi_i
);
  import net_pkg::*;

  localparam int CRED_W = $clog2(`XCEL_MAX_CREDITS + 1);

  slave_req_t        req_in;
  ret_t              ret_in;
  coord_x_t          rep_x_q;
  coord_y_t          rep_y_q;
  logic [CRED_W-1:0] outstanding_q;
  logic              has_credit;
  logic              take;
  logic              give;

  // --------------------
  // slave side
  always_comb begin
    req_in.op    = req_in_op_i;
    req_in.epa   = req_in_epa_i;
    req_in.data  = req_in_data_i;
    req_in.mask  = req_in_mask_i;
    req_in.src_x = req_in_src_x_i;
    req_in.src_y = req_in_src_y_i;
  end

  stream_fifo #(.elem_t(slave_req_t)) req_fifo_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .push_i   (req_in_v_i),
    .data_i   (req_in),
    .pop_i    (in_yumi_i),
    .data_o   (in_req_o),
    .v_o      (in_v_o),
    .full_o   ()
  );

  // requester of the popped entry, reply goes out next cycle
  always_ff @(posedge clk_i) begin
    if (in_yumi_i) begin
      rep_x_q <= in_req_o.src_x;
      rep_y_q <= in_req_o.src_y;
    end
  end

  assign rep_v_o     = returning_v_i;
  assign rep_data_o  = returning_data_i;
  assign rep_dst_x_o = rep_x_q;
  assign rep_dst_y_o = rep_y_q;

  // --------------------
  // master side credits
  assign has_credit  = (outstanding_q != CRED_W'(`XCEL_MAX_CREDITS));
  assign out_ready_o = net_ready_i && ((out_op_i != OP_LOAD) || has_credit);
  assign take        = out_v_i && out_ready_o && (out_op_i == OP_LOAD);
  assign give        = ret_in_v_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      outstanding_q <= '0;
    end else if (take && !give) begin
      outstanding_q <= outstanding_q + 1'b1;
    end else if (give && !take) begin
      outstanding_q <= outstanding_q - 1'b1;
    end
  end

  always_comb begin
    ret_in.data    = ret_in_data_i;
    ret_in.load_id = ret_in_load_id_i;
  end

  stream_fifo #(.elem_t(ret_t)) ret_fifo_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .push_i   (ret_in_v_i),
    .data_i   (ret_in),
    .pop_i    (returned_yumi_i),
    .data_o   (returned_o),
    .v_o      (returned_v_o),
    .full_o   ()
  );

endmodule

// ==== pkt_encode.sv ====
// global address to packet field encoder
`timescale 1ns/1ps
`include "xcel_defs.svh"

module pkt_encode (
  input  net_pkg::coord_x_t my_x_i,
  input  net_pkg::coord_y_t my_y_i,
  input  net_pkg::data_t    addr_i,
  input  net_pkg::op_e      op_i,
  input  net_pkg::data_t    data_i,
  input  net_pkg::mask_t    mask_i,
  input  net_pkg::load_id_t load_id_i,
  output net_pkg::op_e      out_op_o,
  output net_pkg::epa_t     out_epa_o,
  output net_pkg::data_t    out_data_o,
  output net_pkg::mask_t    out_mask_o,
  output net_pkg::coord_x_t out_dst_x_o,
  output net_pkg::coord_y_t out_dst_y_o,
  output net_pkg::coord_x_t out_src_x_o,
  output net_pkg::coord_y_t out_src_y_o,
  output net_pkg::load_id_t out_load_id_o
);
  import net_pkg::*;

  localparam int X_LSB = `XCEL_EPA_W + 2;
  localparam int Y_LSB = X_LSB + `XCEL_X_W;

  // byte address: y | x | word epa | byte offset
  assign out_epa_o   = addr_i[X_LSB-1:2];
  assign out_dst_x_o = addr_i[Y_LSB-1:X_LSB];
  assign out_dst_y_o = addr_i[Y_LSB+`XCEL_Y_W-1:Y_LSB];
  assign out_src_x_o = my_x_i;
  assign out_src_y_o = my_y_i;
  assign out_op_o    = op_i;
  assign out_mask_o  = mask_i;

  // loads carry only their id, stores only their data
  assign out_data_o    = (op_i == OP_LOAD) ? '0 : data_i;
  assign out_load_id_o = (op_i == OP_LOAD) ? load_id_i : '0;

endmodule

// ==== stream_xcel.sv ====
// streaming accelerator: CSR slave plus load, scale and store engine
`timescale 1ns/1ps
`include "xcel_defs.svh"

module stream_xcel (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                in_v_i,
  input  net_pkg::slave_req_t in_req_i,
  output logic                in_yumi_o,
  output logic                returning_v_o,
  output net_pkg::data_t      returning_data_o,
  output logic                out_v_o,
  output net_pkg::data_t      out_addr_o,
  output net_pkg::op_e        out_op_o,
  output net_pkg::data_t      out_data_o,
  output net_pkg::mask_t      out_mask_o,
  output net_pkg::load_id_t   out_load_id_o,
  input  logic                out_ready_i,
  input  logic                returned_v_i,
  input  net_pkg::ret_t       returned_i,
  output logic                returned_yumi_o,
  input  net_pkg::data_t      csr_count_i,
  input  net_pkg::data_t      load_count_i,
  input  net_pkg::data_t      ret_count_i
);
  import net_pkg::*;
  import xcel_pkg::*;

  localparam int IDX_W = `XCEL_LOAD_ID_W + 1;

  xcel_state_e      state_q;
  data_t            src_q;
  data_t            dst_q;
  data_t            len_q;
  data_t            scale_q;
  data_t            sum_q;
  logic [IDX_W-1:0] ld_idx_q;
  logic [IDX_W-1:0] st_cnt_q;
  logic             st_pend_q;
  data_t            st_addr_q;
  data_t            st_data_q;
  logic             rep_rd_q;
  csr_e             rd_csr_q;
  csr_e             csr_idx;
  logic             csr_wr;
  logic             go;
  logic             ld_fire;
  logic             st_fire;
  logic             ld_last;
  logic             st_last;
  data_t            rd_data;

  // --------------------
  // CSR slave
  assign in_yumi_o = in_v_i;
  assign csr_idx   = csr_e'(in_req_i.epa[3:0]);
  assign csr_wr    = in_v_i && (in_req_i.op == OP_STORE);
  assign go        = csr_wr && (csr_idx == CSR_GO) && (state_q == IDLE) && (len_q != '0);

  // read data formed in the reply cycle so the profiler count includes this read
  always_comb begin
    case (rd_csr_q)
      CSR_GO:       rd_data = data_t'(state_q != IDLE);
      CSR_SRC:      rd_data = src_q;
      CSR_DST:      rd_data = dst_q;
      CSR_LEN:      rd_data = len_q;
      CSR_SCALE:    rd_data = scale_q;
      CSR_SUM:      rd_data = sum_q;
      CSR_PROF_CSR: rd_data = csr_count_i;
      CSR_PROF_LD:  rd_data = load_count_i;
      CSR_PROF_RET: rd_data = ret_count_i;
      default:      rd_data = '0;
    endcase
  end

  assign returning_data_o = rep_rd_q ? rd_data : '0;

  // --------------------
  // master port, a pending store wins over the next load
  always_comb begin
    out_v_o       = st_pend_q || (state_q == RUN);
    out_mask_o    = '1;
    out_load_id_o = ld_idx_q[`XCEL_LOAD_ID_W-1:0];
    if (st_pend_q) begin
      out_op_o   = OP_STORE;
      out_addr_o = st_addr_q;
      out_data_o = st_data_q;
    end else begin
      out_op_o   = OP_LOAD;
      out_addr_o = src_q + data_t'({ld_idx_q, 2'b00});
      out_data_o = '0;
    end
  end

  assign ld_fire         = out_v_o && out_ready_i && !st_pend_q;
  assign st_fire         = st_pend_q && out_ready_i;
  assign ld_last         = (data_t'(ld_idx_q) == len_q - 1'b1);
  assign st_last         = (data_t'(st_cnt_q) == len_q - 1'b1);
  assign returned_yumi_o = returned_v_i && !st_pend_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q       <= IDLE;
      src_q         <= '0;
      dst_q         <= '0;
      len_q         <= '0;
      scale_q       <= '0;
      sum_q         <= '0;
      ld_idx_q      <= '0;
      st_cnt_q      <= '0;
      st_pend_q     <= 1'b0;
      returning_v_o <= 1'b0;
      rep_rd_q      <= 1'b0;
    end else begin
      returning_v_o <= in_yumi_o;
      rep_rd_q      <= in_v_i && (in_req_i.op == OP_LOAD);
      if (csr_wr) begin
        case (csr_idx)
          CSR_SRC:   src_q <= in_req_i.data;
          CSR_DST:   dst_q <= in_req_i.data;
          CSR_LEN:   len_q <= in_req_i.data;
          CSR_SCALE: scale_q <= in_req_i.data;
          default:   ;
        endcase
      end
      if (go) begin
        state_q  <= RUN;
        sum_q    <= '0;
        ld_idx_q <= '0;
        st_cnt_q <= '0;
      end
      if (ld_fire) begin
        ld_idx_q <= ld_idx_q + 1'b1;
        if (ld_last) state_q <= DRAIN;
      end
      // returned word: accumulate and queue its store
      if (returned_yumi_o) begin
        st_pend_q <= 1'b1;
        sum_q     <= sum_q + returned_i.data;
      end else if (st_fire) begin
        st_pend_q <= 1'b0;
        st_cnt_q  <= st_cnt_q + 1'b1;
        if (st_last) state_q <= IDLE;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_yumi_o) rd_csr_q <= csr_idx;
    if (returned_yumi_o) begin
      st_addr_q <= dst_q + data_t'({returned_i.load_id, 2'b00});
      st_data_q <= returned_i.data * scale_q;
    end
  end

endmodule

// ==== xcel_profiler.sv ====
// saturating event counters for CSR pops, loads and returns
`timescale 1ns/1ps
`include "xcel_defs.svh"

module xcel_profiler (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  logic           csr_v_i,
  input  logic           load_v_i,
  input  logic           ret_v_i,
  output net_pkg::data_t csr_count_o,
  output net_pkg::data_t load_count_o,
  output net_pkg::data_t ret_count_o
);

  localparam int N_CNT = 3;

  logic [N_CNT-1:0]                   inc;
  logic [N_CNT-1:0][`XCEL_DATA_W-1:0] cnt_q;

  assign inc = {ret_v_i, load_v_i, csr_v_i};

  // hold at all ones instead of wrapping
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < N_CNT; i++) begin
        if (inc[i] && (cnt_q[i] != '1)) cnt_q[i] <= cnt_q[i] + 1'b1;
      end
    end
  end

  assign csr_count_o  = cnt_q[0];
  assign load_count_o = cnt_q[1];
  assign ret_count_o  = cnt_q[2];

endmodule

// ==== xcel_tile.sv ====
// accelerator tile top: endpoint, packet encoder, streaming engine
// and profiler
`timescale 1ns/1ps

module xcel_tile (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  net_pkg::coord_x_t my_x_i,
  input  net_pkg::coord_y_t my_y_i,
  input  logic              req_in_v_i,
  input  net_pkg::op_e      req_in_op_i,
  input  net_pkg::epa_t     req_in_epa_i,
  input  net_pkg::data_t    req_in_data_i,
  input  net_pkg::mask_t    req_in_mask_i,
  input  net_pkg::coord_x_t req_in_src_x_i,
  input  net_pkg::coord_y_t req_in_src_y_i,
  input  logic              ret_in_v_i,
  input  net_pkg::data_t    ret_in_data_i,
  input  net_pkg::load_id_t ret_in_load_id_i,
  output logic              out_v_o,
  input  logic              out_ready_i,
  output net_pkg::op_e      out_op_o,
  output net_pkg::epa_t     out_epa_o,
  output net_pkg::data_t    out_data_o,
  output net_pkg::mask_t    out_mask_o,
  output net_pkg::coord_x_t out_dst_x_o,
  output net_pkg::coord_y_t out_dst_y_o,
  output net_pkg::coord_x_t out_src_x_o,
  output net_pkg::coord_y_t out_src_y_o,
  output net_pkg::load_id_t out_load_id_o,
  output logic              rep_v_o,
  output net_pkg::data_t    rep_data_o,
  output net_pkg::coord_x_t rep_dst_x_o,
  output net_pkg::coord_y_t rep_dst_y_o
);
  import net_pkg::*;

  logic       in_v;
  slave_req_t in_req;
  logic       in_yumi;
  logic       returning_v;
  data_t      returning_data;
  logic       xcel_ready;
  data_t      xcel_addr;
  op_e        xcel_op;
  data_t      xcel_data;
  mask_t      xcel_mask;
  load_id_t   xcel_load_id;
  logic       returned_v;
  ret_t       returned;
  logic       returned_yumi;
  logic       load_acc;
  data_t      csr_count;
  data_t      load_count;
  data_t      ret_count;

  // a load counts once the endpoint takes it
  assign load_acc = out_v_o && xcel_ready && (xcel_op == OP_LOAD);

  net_endpoint endpoint_i (
    .*,
    .in_v_o           (in_v),
    .in_req_o         (in_req),
    .in_yumi_i        (in_yumi),
    .returning_v_i    (returning_v),
    .returning_data_i (returning_data),
    .out_v_i          (out_v_o),
    .out_op_i         (xcel_op),
    .net_ready_i      (out_ready_i),
    .out_ready_o      (xcel_ready),
    .returned_v_o     (returned_v),
    .returned_o       (returned),
    .returned_yumi_i  (returned_yumi)
  );

  pkt_encode encode_i (
    .*,
    .addr_i    (xcel_addr),
    .op_i      (xcel_op),
    .data_i    (xcel_data),
    .mask_i    (xcel_mask),
    .load_id_i (xcel_load_id)
  );

  stream_xcel xcel_i (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .in_v_i           (in_v),
    .in_req_i         (in_req),
    .in_yumi_o        (in_yumi),
    .returning_v_o    (returning_v),
    .returning_data_o (returning_data),
    .out_v_o          (out_v_o),
    .out_addr_o       (xcel_addr),
    .out_op_o         (xcel_op),
    .out_data_o       (xcel_data),
    .out_mask_o       (xcel_mask),
    .out_load_id_o    (xcel_load_id),
    .out_ready_i      (xcel_ready),
    .returned_v_i     (returned_v),
    .returned_i       (returned),
    .returned_yumi_o  (returned_yumi),
    .csr_count_i      (csr_count),
    .load_count_i     (load_count),
    .ret_count_i      (ret_count)
  );

  xcel_profiler profiler_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .csr_v_i      (in_yumi),
    .load_v_i     (load_acc),
    .ret_v_i      (returned_yumi),
    .csr_count_o  (csr_count),
    .load_count_o (load_count),
    .ret_count_o  (ret_count)
  );

endmodule

// ==== tb_xcel_tile.sv ====
// directed testbench for the accelerator tile
// memory model with random ready and out-of-order load returns
`timescale 1ns/1ps
`include "xcel_defs.svh"

module tb_xcel_tile;
  import net_pkg::*;
  import xcel_pkg::*;

  localparam int CSR_TIMEOUT = 200;
  localparam int RUN_POLLS   = 400;
  localparam int MAX_CRED    = `XCEL_MAX_CREDITS;
  localparam int Q_DEPTH     = `XCEL_FIFO_DEPTH;

  typedef struct packed {
    load_id_t id;
    data_t    data;
  } pend_t;

  logic     clk_i;
  logic     arst_n_i;
  coord_x_t my_x_i;
  coord_y_t my_y_i;
  logic     req_in_v_i;
  op_e      req_in_op_i;
  epa_t     req_in_epa_i;
  data_t    req_in_data_i;
  mask_t    req_in_mask_i;
  coord_x_t req_in_src_x_i;
  coord_y_t req_in_src_y_i;
  logic     ret_in_v_i;
  data_t    ret_in_data_i;
  load_id_t ret_in_load_id_i;
  logic     out_v_o;
  logic     out_ready_i;
  op_e      out_op_o;
  epa_t     out_epa_o;
  data_t    out_data_o;
  mask_t    out_mask_o;
  coord_x_t out_dst_x_o;
  coord_y_t out_dst_y_o;
  coord_x_t out_src_x_o;
  coord_y_t out_src_y_o;
  load_id_t out_load_id_o;
  logic     rep_v_o;
  data_t    rep_data_o;
  coord_x_t rep_dst_x_o;
  coord_y_t rep_dst_y_o;

  // memory model state, keyed by global byte address
  data_t  mem [data_t];
  bit     stored [data_t];
  pend_t  pend_q [$];
  integer seed = 81;
  int     outstanding = 0;
  int     in_flight = 0;
  int     next_ld = 0;
  int     n_stores = 0;
  int     cur_len = 0;
  int     len_total = 0;
  int     csr_sent = 0;
  data_t  cur_src;
  data_t  cur_dst;
  string  test_name = "init";

  xcel_tile dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // --------------------
  // error handling and compare tasks
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_data(input string what, input data_t exp, input data_t act);
    if (exp !== act) begin
      stop_on_error($sformatf("[FAIL] %s %s: expected 0x%08h actual 0x%08h",
                              test_name, what, exp, act));
    end
  endtask

  task automatic check_coord(input string what, input coord_x_t exp, input coord_x_t act);
    if (exp !== act) begin
      stop_on_error($sformatf("[FAIL] %s %s: expected %0d actual %0d",
                              test_name, what, exp, act));
    end
  endtask

  task automatic check_epa(input string what, input epa_t exp, input epa_t act);
    if (exp !== act) begin
      stop_on_error($sformatf("[FAIL] %s %s: expected 0x%06h actual 0x%06h",
                              test_name, what, exp, act));
    end
  endtask

  task automatic check_id(input string what, input load_id_t exp, input load_id_t act);
    if (exp !== act) begin
      stop_on_error($sformatf("[FAIL] %s %s: expected %0d actual %0d",
                              test_name, what, exp, act));
    end
  endtask

  // --------------------
  // memory model, all decisions taken at the falling edge
  initial begin : mem_model
    pend_t p;
    data_t addr;
    int    k;
    logic  rdy;
    logic  ret_v;
    @(posedge arst_n_i);
    forever begin
      @(negedge clk_i);
      rdy   = ($random(seed) & 3) != 0;
      ret_v = 1'b0;
      // hold back returns while the returned queue could be full
      if (pend_q.size() > 0 && in_flight < Q_DEPTH && ($random(seed) & 1)) begin
        k = ($random(seed) & 32'h7fff_ffff) % pend_q.size();
        p = pend_q[k];
        pend_q.delete(k);
        ret_v = 1'b1;
      end
      if (out_v_o && rdy && out_op_o == OP_STORE) begin
        addr = {out_dst_y_o, out_dst_x_o, out_epa_o, 2'b00};
        if (stored.exists(addr)) stop_on_error("store address repeats within a run");
        if ((addr - cur_dst) >= data_t'(cur_len * 4)) begin
          stop_on_error("store outside the destination buffer");
        end
        check_data("store mask", data_t'(mask_t'('1)), data_t'(out_mask_o));
        stored[addr] = 1'b1;
        mem[addr]    = out_data_o;
        in_flight--;
        n_stores++;
      end else if (out_v_o && rdy && outstanding < MAX_CRED) begin
        // a load with no free credit is refused inside the tile,
        // so a credit error shows up as a wrong load id
        if (next_ld >= cur_len) stop_on_error("load issued beyond LEN");
        addr = cur_src + data_t'(next_ld * 4);
        check_coord("load dst_y", addr[31:28], out_dst_y_o);
        check_coord("load dst_x", addr[27:24], out_dst_x_o);
        check_epa("load epa", addr[23:2], out_epa_o);
        check_coord("load src_x", my_x_i, out_src_x_o);
        check_coord("load src_y", my_y_i, out_src_y_o);
        check_id("load id", load_id_t'(next_ld), out_load_id_o);
        if (!mem.exists(addr)) stop_on_error("load from an address never written");
        pend_q.push_back('{id: out_load_id_o, data: mem[addr]});
        next_ld++;
        outstanding++;
      end
      if (ret_v) begin
        outstanding--;
        in_flight++;
      end
      out_ready_i      = rdy;
      ret_in_v_i       = ret_v;
      ret_in_data_i    = ret_v ? p.data : '0;
      ret_in_load_id_i = ret_v ? p.id : '0;
    end
  end

  // --------------------
  // CSR access from a requester tile
  task automatic csr_access(input op_e op, input csr_e idx, input data_t wdata,
                            input coord_x_t sx, input coord_y_t sy, output data_t rdata);
    int waited;
    @(negedge clk_i);
    req_in_v_i     = 1'b1;
    req_in_op_i    = op;
    req_in_epa_i   = epa_t'(idx);
    req_in_data_i  = wdata;
    req_in_mask_i  = '1;
    req_in_src_x_i = sx;
    req_in_src_y_i = sy;
    csr_sent++;
    @(negedge clk_i);
    req_in_v_i = 1'b0;
    waited     = 0;
    while (!rep_v_o) begin
      if (waited == CSR_TIMEOUT) stop_on_error("no CSR reply before the timeout");
      waited++;
      @(negedge clk_i);
    end
    check_coord("reply dst_x", sx, rep_dst_x_o);
    check_coord("reply dst_y", sy, rep_dst_y_o);
    rdata = rep_data_o;
  endtask

  task automatic csr_write(input csr_e idx, input data_t wdata,
                           input coord_x_t sx, input coord_y_t sy);
    data_t rd;
    csr_access(OP_STORE, idx, wdata, sx, sy, rd);
    check_data("write reply", '0, rd);
  endtask

  task automatic csr_read(input csr_e idx, input coord_x_t sx, input coord_y_t sy,
                          output data_t rd);
    csr_access(OP_LOAD, idx, '0, sx, sy, rd);
  endtask

  task automatic run_stream(input coord_x_t sx, input coord_y_t sy);
    data_t busy;
    int    polls;
    csr_write(CSR_GO, 32'd1, sx, sy);
    polls = 0;
    do begin
      if (polls == RUN_POLLS) stop_on_error("run did not finish before the timeout");
      polls++;
      csr_read(CSR_GO, sx, sy, busy);
    end while (busy != '0);
  endtask

  // --------------------
  // tests
  task automatic test_reset_state();
    data_t rd;
    test_name = "reset";
    repeat (20) begin
      @(negedge clk_i);
      if (out_v_o !== 1'b0 || rep_v_o !== 1'b0) stop_on_error("valid output high after reset");
    end
    csr_read(CSR_SUM, 4'd1, 4'd1, rd);
    check_data("SUM", '0, rd);
    csr_read(CSR_PROF_LD, 4'd1, 4'd1, rd);
    check_data("PROF_LD", '0, rd);
    csr_read(CSR_PROF_RET, 4'd1, 4'd1, rd);
    check_data("PROF_RET", '0, rd);
    csr_read(CSR_PROF_CSR, 4'd1, 4'd1, rd);
    check_data("PROF_CSR", data_t'(csr_sent), rd);
  endtask

  task automatic test_csr_access();
    csr_e  regs [4] = '{CSR_SRC, CSR_DST, CSR_LEN, CSR_SCALE};
    data_t vals [4] = '{32'h2300_0400, 32'h5700_1000, 32'd17, 32'hdead_beef};
    data_t rd;
    test_name = "csr_access";
    for (int i = 0; i < 4; i++) begin
      csr_write(regs[i], vals[i], coord_x_t'(i + 2), coord_y_t'(9 - i));
    end
    for (int i = 0; i < 4; i++) begin
      csr_read(regs[i], coord_x_t'(12 - i), coord_y_t'(i + 5), rd);
      check_data("readback", vals[i], rd);
    end
  endtask

  task automatic test_stream(input int len, input data_t scale);
    data_t w;
    data_t exp_sum;
    data_t rd;
    test_name = $sformatf("stream_len%0d", len);
    cur_src   = 32'h2300_0400;
    cur_dst   = 32'h5700_1000;
    exp_sum   = '0;
    stored.delete();
    for (int i = 0; i < len; i++) begin
      w = $random(seed);
      mem[cur_src + data_t'(i * 4)] = w;
      exp_sum = exp_sum + w;
    end
    next_ld  = 0;
    n_stores = 0;
    cur_len  = len;
    csr_write(CSR_SRC, cur_src, 4'd3, 4'd2);
    csr_write(CSR_DST, cur_dst, 4'd3, 4'd2);
    csr_write(CSR_LEN, data_t'(len), 4'd3, 4'd2);
    csr_write(CSR_SCALE, scale, 4'd3, 4'd2);
    run_stream(4'd3, 4'd2);
    len_total = len_total + len;
    check_data("store count", data_t'(len), data_t'(n_stores));
    for (int i = 0; i < len; i++) begin
      w = mem[cur_src + data_t'(i * 4)] * scale;
      check_data($sformatf("dst word %0d", i), w, mem[cur_dst + data_t'(i * 4)]);
    end
    csr_read(CSR_SUM, 4'd3, 4'd2, rd);
    check_data("SUM", exp_sum, rd);
  endtask

  task automatic test_profiler();
    data_t rd;
    test_name = "profiler";
    csr_read(CSR_PROF_LD, 4'd0, 4'd7, rd);
    check_data("PROF_LD", data_t'(len_total), rd);
    csr_read(CSR_PROF_RET, 4'd0, 4'd7, rd);
    check_data("PROF_RET", data_t'(len_total), rd);
    csr_read(CSR_PROF_CSR, 4'd0, 4'd7, rd);
    check_data("PROF_CSR", data_t'(csr_sent), rd);
  endtask

  initial begin : main
    arst_n_i         = 1'b0;
    my_x_i           = 4'd6;
    my_y_i           = 4'd1;
    req_in_v_i       = 1'b0;
    req_in_op_i      = OP_LOAD;
    req_in_epa_i     = '0;
    req_in_data_i    = '0;
    req_in_mask_i    = '0;
    req_in_src_x_i   = '0;
    req_in_src_y_i   = '0;
    ret_in_v_i       = 1'b0;
    ret_in_data_i    = '0;
    ret_in_load_id_i = '0;
    out_ready_i      = 1'b0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    test_reset_state();
    test_csr_access();
    test_stream(1, 32'd3);
    test_stream(40, 32'h0001_0003);
    test_profiler();
    if (pend_q.size() != 0 || outstanding != 0) begin
      stop_on_error("loads still outstanding after the last run");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

// ==== xcel_tile.f ====
+incdir+.
net_pkg.sv
xcel_pkg.sv
stream_fifo.sv
net_endpoint.sv
pkt_encode.sv
stream_xcel.sv
xcel_profiler.sv
xcel_tile.sv
tb_xcel_tile.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_xcel_tile
RTL_TOP    := xcel_tile
FILELIST   := xcel_tile.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard *.svh)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
